/* filelist.f */
verilog/xt_bus_pkg.sv
verilog/xt_bus_decoder.sv
verilog/ems_page_mapper.sv
verilog/xt_bus_readback.sv
verilog/xt_bus_glue.sv
tb/xt_bus_glue_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f \
	--top-module xt_bus_glue_tb -o xt_bus_glue_sim

output=$(./obj_dir/xt_bus_glue_sim 2>&1) || true
echo "$output"

if grep -q "RESULT: PASS" <<< "$output"; then
	exit 0
fi
exit 1

/* tb/xt_bus_glue_tb.sv */
`timescale 1ns/1ps

module xt_bus_glue_tb;

	localparam int CLOCK_HALF = 50;
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY = 1;
	localparam int SAMPLE_DELAY = 40;
	localparam int READ_TIMEOUT = 8;
	localparam int MAX_LINES = 256;

	logic                  clock;
	logic                  reset;
	xt_bus_pkg::cpu_addr_t address;
	xt_bus_pkg::bus_data_t write_data;
	logic                  io_read_n;
	logic                  io_write_n;
	logic                  memory_read_n;
	logic                  address_enable_n;
	logic                  ems_enabled;
	logic [1:0]            ems_window;
	logic [7:0]            block_select_n;
	xt_bus_pkg::mem_addr_t mem_address;
	xt_bus_pkg::bus_data_t read_data;
	logic                  data_valid;

	int error_count;
	int test_errors;
	int test_count;
	int failed_tests;
	int fd;

	xt_bus_glue i_xt_bus_glue (
		.clock              (clock),
		.reset              (reset),
		.address_i          (address),
		.data_i             (write_data),
		.io_read_n_i        (io_read_n),
		.io_write_n_i       (io_write_n),
		.memory_read_n_i    (memory_read_n),
		.address_enable_n_i (address_enable_n),
		.ems_enabled_i      (ems_enabled),
		.ems_window_i       (ems_window),
		.block_select_n_o   (block_select_n),
		.mem_address_o      (mem_address),
		.data_o             (read_data),
		.data_valid_o       (data_valid)
	);

	always #CLOCK_HALF clock = ~clock;

	// inputs change just after the rising edge
	task automatic step_clock();
		@(posedge clock);
		#DRIVE_DELAY;
	endtask

	task automatic drive_idle();
		address = '0;
		write_data = '0;
		io_read_n = 1'b1;
		io_write_n = 1'b1;
		memory_read_n = 1'b1;
		address_enable_n = 1'b1;
	endtask

	task automatic count_failure();
		error_count++;
		test_errors++;
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, name, actual, expected);
			count_failure();
		end
	endtask

	// window select and enable stay in force until the next S line
	task automatic configure_ems(input logic [31:0] window_field,
		input logic [31:0] enable_field);
		ems_window = window_field[1:0];
		ems_enabled = enable_field[0];
		step_clock();
	endtask

	task automatic write_port(input logic [31:0] port_addr, input logic [31:0] value);
		address = port_addr[19:0];
		write_data = value[7:0];
		address_enable_n = 1'b0;
		io_write_n = 1'b0;
		step_clock();
		drive_idle();
		repeat (2) step_clock();
	endtask

	task automatic read_port(input logic [31:0] port_addr, input logic [31:0] expected);
		int waited;
		address = port_addr[19:0];
		address_enable_n = 1'b0;
		io_read_n = 1'b0;
		step_clock();
		drive_idle();
		// read-back is registered, valid shows up after the strobe cycle
		waited = 0;
		while (!data_valid && waited < READ_TIMEOUT) begin
			step_clock();
			waited++;
		end
		if (data_valid) begin
			check_value("data_o", {24'h0, read_data}, expected);
		end else begin
			$display("no data_valid_o within %0d cycles of the read of port 0x%0h",
				READ_TIMEOUT, port_addr);
			count_failure();
		end
		repeat (2) step_clock();
	endtask

	// a port that no register answers must never raise valid
	task automatic expect_no_response(input logic [31:0] port_addr);
		int  waited;
		logic rose;
		address = port_addr[19:0];
		address_enable_n = 1'b0;
		io_read_n = 1'b0;
		step_clock();
		drive_idle();
		rose = 1'b0;
		for (waited = 0; waited < READ_TIMEOUT; waited++) begin
			if (data_valid) begin
				rose = 1'b1;
			end
			step_clock();
		end
		if (rose) begin
			$display("data_valid_o went high for a read of unmapped port 0x%0h", port_addr);
			count_failure();
		end
	endtask

	task automatic probe_block_selects(input logic [31:0] port_addr,
		input logic [31:0] expected);
		address = port_addr[19:0];
		address_enable_n = 1'b0;
		io_read_n = 1'b0;
		#SAMPLE_DELAY;
		check_value("block_select_n_o", {24'h0, block_select_n}, expected);
		step_clock();
		drive_idle();
		repeat (2) step_clock();
	endtask

	task automatic translate_memory(input logic [31:0] mem_addr, input logic [31:0] expected);
		address = mem_addr[19:0];
		address_enable_n = 1'b0;
		memory_read_n = 1'b0;
		#SAMPLE_DELAY;
		check_value("mem_address_o", {11'h0, mem_address}, expected);
		// no I/O strobe, so no block is selected
		check_value("block_select_n_o", {24'h0, block_select_n}, 32'h0000_00FF);
		step_clock();
		drive_idle();
		repeat (2) step_clock();
	endtask

	task automatic report_test(input logic [7:0] op, input int line_no);
		if (test_errors == 0) begin
			$display("test %0d (%s, line %0d) ok", test_count, op, line_no);
		end else begin
			failed_tests++;
			$display("test %0d (%s, line %0d) failed with %0d errors",
				test_count, op, line_no, test_errors);
		end
	endtask

	task automatic apply_patterns(input int file);
		string       line;
		logic [7:0]  op;
		logic [31:0] field_a;
		logic [31:0] field_b;
		int          fields;
		int          got;
		int          line_no;
		line_no = 0;
		while (!$feof(file) && line_no < MAX_LINES) begin
			got = $fgets(line, file);
			line_no++;
			if (got > 0 && line.len() > 2 && line.getc(0) != "#") begin
				test_errors = 0;
				test_count++;
				fields = $sscanf(line, "%s %h %h", op, field_a, field_b);
				if (fields != 3) begin
					$display("pattern line %0d does not hold three fields", line_no);
					count_failure();
				end else begin
					case (op)
						"S": configure_ems(field_a, field_b);
						"W": write_port(field_a, field_b);
						"R": read_port(field_a, field_b);
						"N": expect_no_response(field_a);
						"B": probe_block_selects(field_a, field_b);
						"M": translate_memory(field_a, field_b);
						default: begin
							$display("unknown operation %s on pattern line %0d", op, line_no);
							count_failure();
						end
					endcase
				end
				report_test(op, line_no);
			end
		end
		if (!$feof(file)) begin
			$display("pattern file is longer than %0d lines", MAX_LINES);
			error_count++;
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		ems_enabled = 1'b0;
		ems_window = 2'd0;
		drive_idle();
		error_count = 0;
		test_errors = 0;
		test_count = 0;
		failed_tests = 0;

		repeat (RESET_CYCLES) @(posedge clock);
		#DRIVE_DELAY;
		reset = 1'b0;
		step_clock();

		fd = $fopen("tb/xt_bus_patterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open the pattern file tb/xt_bus_patterns.txt");
			$display("RESULT: FAIL");
		end else begin
			apply_patterns(fd);
			$fclose(fd);
			$display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
			if (error_count == 0) begin
				$display("RESULT: PASS");
			end else begin
				$display("RESULT: FAIL");
			end
		end
		$finish;
	end

endmodule

/* tb/xt_bus_patterns.txt */
# op addr data, all hex: S window enable, W port byte, R port expected byte
# N port unused (no valid expected), B port expected selects, M address expected translation
# state after reset
R 00378 FF
S 0 1
R 00260 FF
R 00263 FF
M A4123 0A4123
# parallel port latch
W 00378 5A
R 00378 5A
N 00379 0
W 00378 C3
R 00378 C3
# slot 1 mapped to page 5 in window A
W 00261 05
R 00261 05
R 00260 FF
M A4123 114123
M A0123 0A0123
# write codes
W 00261 90
R 00261 05
M A4123 114123
W 00261 FF
R 00261 FF
M A4123 0A4123
W 00261 45
R 00261 05
# window D
S 2 1
M D4000 114000
M A4000 0A4000
# EMS ports ignored while disabled
S 2 0
W 00262 07
N 00262 0
S 2 1
R 00262 FF
# block selects
B 00020 FD
B 00040 FB
B 000E0 7F
B 00120 FF
M B0000 0B0000

/* verilog/ems_page_mapper.sv */
`timescale 1ns/1ps

module ems_page_mapper (
	input  logic                  clock,
	input  logic                  reset,
	input  xt_bus_pkg::cpu_addr_t address_i,
	input  xt_bus_pkg::bus_data_t data_i,
	input  logic                  io_write_n_i,
	input  logic                  mem_cycle_i,
	input  logic                  ems_port_hit_i,
	input  logic [1:0]            ems_window_i,
	output xt_bus_pkg::mem_addr_t mem_address_o,
	output xt_bus_pkg::bus_data_t ems_read_data_o
);

	xt_bus_pkg::ems_page_t page_q [xt_bus_pkg::EMS_SLOTS];
	logic [xt_bus_pkg::EMS_SLOTS-1:0] slot_enabled_q;

	// write pipeline, one cycle between port write and update
	logic                  wr_strobe_q;
	xt_bus_pkg::ems_slot_t wr_slot_q;
	xt_bus_pkg::ems_page_t wr_page_q;
	logic                  wr_enable_q;

	xt_bus_pkg::ems_slot_t port_slot;
	xt_bus_pkg::ems_page_t next_page;
	logic                  next_enable;

	xt_bus_pkg::ems_slot_t mem_slot;
	logic [3:0]            window_bits;
	logic                  window_hit;

	// port 0x260 + n addresses slot n
	assign port_slot = xt_bus_pkg::ems_slot_t'(address_i[1:0]);

	// decode the written byte into page and enable
	always_comb begin
		next_page = page_q[port_slot];
		next_enable = slot_enabled_q[port_slot];
		if (data_i == xt_bus_pkg::EMS_DISABLE_CODE) begin
			next_enable = 1'b0;
		end else if (data_i < xt_bus_pkg::EMS_MAP_LIMIT) begin
			next_page = data_i[5:0];
			next_enable = 1'b1;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wr_strobe_q <= 1'b0;
		end else begin
			wr_strobe_q <= ems_port_hit_i && !io_write_n_i;
		end
	end

	always_ff @(posedge clock) begin
		wr_slot_q <= port_slot;
		wr_page_q <= next_page;
		wr_enable_q <= next_enable;
	end

	// page registers
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			page_q <= '{default: '0};
			slot_enabled_q <= '0;
		end else if (wr_strobe_q) begin
			page_q[wr_slot_q] <= wr_page_q;
			slot_enabled_q[wr_slot_q] <= wr_enable_q;
		end
	end

	// register read, zero-extended page
	assign ems_read_data_o = slot_enabled_q[port_slot] ? {2'b00, page_q[port_slot]} :
		xt_bus_pkg::EMS_READ_DISABLED;

	// page frame location, selects 2 and 3 both land at segment D000
	always_comb begin
		case (ems_window_i)
			2'd0:    window_bits = xt_bus_pkg::EMS_WINDOW_A;
			2'd1:    window_bits = xt_bus_pkg::EMS_WINDOW_C;
			default: window_bits = xt_bus_pkg::EMS_WINDOW_D;
		endcase
	end

	// 16k slot within the frame
	assign mem_slot = xt_bus_pkg::ems_slot_t'(address_i[15:14]);

	assign window_hit = mem_cycle_i && (address_i[19:16] == window_bits) &&
		slot_enabled_q[mem_slot];

	assign mem_address_o = window_hit ? {1'b1, page_q[mem_slot], address_i[13:0]} :
		{1'b0, address_i};

	// a slot only turns on from a byte below the map limit
	assert property (@(posedge clock) disable iff (reset)
		(wr_strobe_q && wr_enable_q && !slot_enabled_q[wr_slot_q]) |->
		($past(data_i) < xt_bus_pkg::EMS_MAP_LIMIT))
		else $error("EMS slot %0d enabled by an out-of-range write", wr_slot_q);

endmodule

/* verilog/xt_bus_decoder.sv */
`timescale 1ns/1ps

module xt_bus_decoder (
	input  xt_bus_pkg::cpu_addr_t address_i,
	input  logic                  io_read_n_i,
	input  logic                  io_write_n_i,
	input  logic                  address_enable_n_i,
	input  logic                  ems_enabled_i,
	output logic                  io_cycle_o,
	output logic                  mem_cycle_o,
	output logic [7:0]            block_select_n_o,
	output logic                  ems_port_hit_o,
	output logic                  lpt_port_hit_o
);

	logic        low_io_space;
	logic [15:0] port_address;

	// only the low 16 bits matter for I/O decoding
	assign port_address = address_i[15:0];

	// cycle type
	assign io_cycle_o = !io_read_n_i || !io_write_n_i;
	assign mem_cycle_o = !io_cycle_o && !address_enable_n_i;

	// system board ports 0x000 to 0x0FF
	assign low_io_space = io_cycle_o && !address_enable_n_i && (address_i[9:8] == 2'b00);

	// one select per 32-port block
	always_comb begin
		block_select_n_o = 8'hFF;
		if (low_io_space) begin
			block_select_n_o[address_i[7:5]] = 1'b0;
		end
	end

	// four consecutive EMS page ports
	assign ems_port_hit_o = io_cycle_o && !address_enable_n_i && ems_enabled_i &&
		(port_address[15:2] == xt_bus_pkg::EMS_PORT_BASE[15:2]);

	assign lpt_port_hit_o = io_cycle_o && (port_address == xt_bus_pkg::LPT_PORT);

	// the read-back mux relies on at most one register port hit
	always_comb begin
		assert (!(ems_port_hit_o && lpt_port_hit_o))
			else $error("EMS and LPT port hits overlap at 0x%h", port_address);
	end

endmodule

/* verilog/xt_bus_glue.sv */
`timescale 1ns/1ps

module xt_bus_glue (
	input  logic                  clock,
	input  logic                  reset,
	input  xt_bus_pkg::cpu_addr_t address_i,
	input  xt_bus_pkg::bus_data_t data_i,
	input  logic                  io_read_n_i,
	input  logic                  io_write_n_i,
	// memory data path sits outside this block
	input  logic                  memory_read_n_i,
	input  logic                  address_enable_n_i,
	input  logic                  ems_enabled_i,
	input  logic [1:0]            ems_window_i,
	output logic [7:0]            block_select_n_o,
	output xt_bus_pkg::mem_addr_t mem_address_o,
	output xt_bus_pkg::bus_data_t data_o,
	output logic                  data_valid_o
);

	logic                  mem_cycle;
	logic                  ems_port_hit;
	logic                  lpt_port_hit;
	xt_bus_pkg::bus_data_t ems_read_data;

	// address and cycle decode
	xt_bus_decoder i_xt_bus_decoder (
		.address_i          (address_i),
		.io_read_n_i        (io_read_n_i),
		.io_write_n_i       (io_write_n_i),
		.address_enable_n_i (address_enable_n_i),
		.ems_enabled_i      (ems_enabled_i),
		// I/O cycle flag only feeds the port hits inside the decoder
		.io_cycle_o         (),
		.mem_cycle_o        (mem_cycle),
		.block_select_n_o   (block_select_n_o),
		.ems_port_hit_o     (ems_port_hit),
		.lpt_port_hit_o     (lpt_port_hit)
	);

	// EMS page registers and address translation
	ems_page_mapper i_ems_page_mapper (
		.clock           (clock),
		.reset           (reset),
		.address_i       (address_i),
		.data_i          (data_i),
		.io_write_n_i    (io_write_n_i),
		.mem_cycle_i     (mem_cycle),
		.ems_port_hit_i  (ems_port_hit),
		.ems_window_i    (ems_window_i),
		.mem_address_o   (mem_address_o),
		.ems_read_data_o (ems_read_data)
	);

	// parallel port latch and CPU read-back
	xt_bus_readback i_xt_bus_readback (
		.clock           (clock),
		.reset           (reset),
		.data_i          (data_i),
		.io_read_n_i     (io_read_n_i),
		.io_write_n_i    (io_write_n_i),
		.ems_port_hit_i  (ems_port_hit),
		.lpt_port_hit_i  (lpt_port_hit),
		.ems_read_data_i (ems_read_data),
		.data_o          (data_o),
		.data_valid_o    (data_valid_o)
	);

endmodule

/* verilog/xt_bus_pkg.sv */
package xt_bus_pkg;

	// bus widths
	typedef logic [19:0] cpu_addr_t;
	// top bit flags an EMS hit
	typedef logic [20:0] mem_addr_t;
	typedef logic [7:0] bus_data_t;
	typedef logic [5:0] ems_page_t;
	typedef logic [1:0] ems_slot_t;

	// EMS register block, one port per slot
	localparam int EMS_SLOTS = 4;
	localparam logic [15:0] EMS_PORT_BASE = 16'h0260;

	// parallel port data register
	localparam logic [15:0] LPT_PORT = 16'h0378;

	// page register write codes
	localparam logic [7:0] EMS_DISABLE_CODE = 8'hFF;
	localparam logic [7:0] EMS_MAP_LIMIT = 8'h80;

	// address bits 19..16 of the 64k page frame
	localparam logic [3:0] EMS_WINDOW_A = 4'hA;
	localparam logic [3:0] EMS_WINDOW_C = 4'hC;
	localparam logic [3:0] EMS_WINDOW_D = 4'hD;

	localparam logic [7:0] LPT_RESET_VALUE = 8'hFF;

	// what a disabled slot reads back as
	localparam logic [7:0] EMS_READ_DISABLED = 8'hFF;

endpackage

/* verilog/xt_bus_readback.sv */
`timescale 1ns/1ps

module xt_bus_readback (
	input  logic                  clock,
	input  logic                  reset,
	input  xt_bus_pkg::bus_data_t data_i,
	input  logic                  io_read_n_i,
	input  logic                  io_write_n_i,
	input  logic                  ems_port_hit_i,
	input  logic                  lpt_port_hit_i,
	input  xt_bus_pkg::bus_data_t ems_read_data_i,
	output xt_bus_pkg::bus_data_t data_o,
	output logic                  data_valid_o
);

	xt_bus_pkg::bus_data_t lpt_data_q;
	logic                  ems_read;
	logic                  lpt_read;

	assign ems_read = ems_port_hit_i && !io_read_n_i;
	assign lpt_read = lpt_port_hit_i && !io_read_n_i;

	// parallel port output latch
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			lpt_data_q <= xt_bus_pkg::LPT_RESET_VALUE;
		end else if (lpt_port_hit_i && !io_write_n_i) begin
			lpt_data_q <= data_i;
		end
	end

	// registered drive onto the CPU bus
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			data_o <= '0;
			data_valid_o <= 1'b0;
		end else if (ems_read) begin
			data_o <= ems_read_data_i;
			data_valid_o <= 1'b1;
		end else if (lpt_read) begin
			data_o <= lpt_data_q;
			data_valid_o <= 1'b1;
		end else begin
			// idle bus reads as zero
			data_o <= '0;
			data_valid_o <= 1'b0;
		end
	end

	// valid data always answers a read strobe one cycle earlier
	assert property (@(posedge clock) disable iff (reset)
		data_valid_o |-> $past(!io_read_n_i))
		else $error("data_valid_o without a preceding I/O read");

endmodule
